/* compile.f */
hdl/zdc_pkg.sv
hdl/rd_port_if.sv
hdl/line_fifo.sv
hdl/nibble_expander.sv
hdl/decomp_mngr.sv
hdl/zdc_top.sv
verif/zdc_tb.sv

/* verif/zdc_tb.sv */
// Pages stay below 0xE00000, chained records from 0xF00000. Waits give up after WAIT_MAX cycles
`timescale 1ns/1ps
`default_nettype none

module zdc_tb
	import zdc_pkg::*;
();
	localparam int WAIT_MAX = 5000;

	logic       clk_i;
	logic       rst_ni;
	logic       trigger;
	addr_t      cpage_addr;
	logic       ar_valid;
	addr_t      ar_addr;
	logic       ar_ready;
	logic       r_valid;
	line_t      r_data;
	logic [1:0] r_resp;
	logic       md_wr_valid;
	addr_t      md_wr_addr;
	line_t      md_wr_data;
	logic       out_valid;
	xline_t     out_data;
	logic       free_push;
	addr_t      free_ptr;
	size_cls_t  free_cls;
	logic       done;
	logic       error;

	// memory image and expected results of the current page
	line_t      mem [addr_t];
	addr_t      page;
	addr_t      exp_ar [$];
	xline_t     exp_out [$];
	addr_t      exp_md_addr;
	line_t      exp_md_data;
	logic       exp_full;
	size_cls_t  exp_cls;
	int         iway_idx;  // read index of the iWay or -1 if never reached
	int         err_at;    // read index answered with a bus error or -1

	// seen by the bus model and monitor
	addr_t      got_ar [$];
	xline_t     got_out [$];
	int         cyc;
	int         rd_num;
	logic       pend;
	addr_t      pend_addr;
	int         pend_wait;
	int         pend_idx;
	int         iway_cyc;
	int         md_cnt;
	int         md_cyc;
	addr_t      md_addr_got;
	line_t      md_data_got;
	int         free_cnt;
	int         free_cyc;
	addr_t      free_ptr_got;
	size_cls_t  free_cls_got;
	int         done_cnt;
	int         done_cyc;

	zdc_top #(.FIFO_DEPTH(16)) u_zdc_top (
		.clk_i, .rst_ni, .trigger, .cpage_addr,
		.ar_valid, .ar_addr, .ar_ready,
		.r_valid, .r_data, .r_resp,
		.md_wr_valid, .md_wr_addr, .md_wr_data,
		.out_valid, .out_data,
		.free_push, .free_ptr, .free_cls,
		.done, .error
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
	endtask

	// unmapped reads still return something tied to the address
	function automatic line_t fill_pattern(input addr_t a);
		return {a, ~a, a ^ 24'h5A5A5A, ~a ^ 24'h0F0F0F, a, 8'hC3};
	endfunction

	function automatic addr_t record_addr(input addr_t base, input int j);
		return (j == 0) ? base : 24'hF00000 + 24'(16 * j);
	endfunction

	// output byte n holds nibble n of the selected half
	function automatic xline_t nibble_spread(input line_t d, input bit upper);
		xline_t x;
		int     first;
		first = upper ? 16 : 0;
		for (int n = 0; n < 16; n++)
			x[8*n +: 8] = {4'h0, d[4*(first + n) +: 4]};
		return x;
	endfunction

	// read model serving one request at a time and capturing the outputs
	always @(posedge clk_i) begin
		cyc = cyc + 1;
		r_valid  <= 1'b0;
		ar_ready <= ($urandom % 4) != 0;  // stall about one cycle in four
		if (pend) begin
			if (pend_wait == 0) begin
				r_valid <= 1'b1;
				r_data  <= mem.exists(pend_addr) ? mem[pend_addr] : fill_pattern(pend_addr);
				r_resp  <= (pend_idx == err_at) ? 2'(1 + $urandom % 3) : 2'b00;
				if (pend_idx == iway_idx)
					iway_cyc = cyc;
				pend = 1'b0;
			end else begin
				pend_wait = pend_wait - 1;
			end
		end
		if (ar_valid && ar_ready) begin
			got_ar.push_back(ar_addr);
			pend      = 1'b1;
			pend_addr = ar_addr;
			pend_wait = $urandom % 4;
			pend_idx  = rd_num;
			rd_num    = rd_num + 1;
		end
		if (out_valid)
			got_out.push_back(out_data);
		if (md_wr_valid) begin
			md_cnt      = md_cnt + 1;
			md_cyc      = cyc;
			md_addr_got = md_wr_addr;
			md_data_got = md_wr_data;
		end
		if (free_push) begin
			free_cnt     = free_cnt + 1;
			free_cyc     = cyc;
			free_ptr_got = free_ptr;
			free_cls_got = free_cls;
		end
		if (done) begin
			done_cnt = done_cnt + 1;
			done_cyc = cyc;
		end
	end

	task automatic apply_reset();
		@(posedge clk_i);
		rst_ni  <= 1'b0;
		trigger <= 1'b0;
		repeat (7) @(posedge clk_i);
		@(negedge clk_i);
		check("done", done, 1'b0);
		check("error", error, 1'b0);
		check("md_wr_valid", md_wr_valid, 1'b0);
		check("free_push", free_push, 1'b0);
		check("out_valid", out_valid, 1'b0);
		check("ar_valid", ar_valid, 1'b0);
		@(posedge clk_i);
		rst_ni <= 1'b1;
	endtask

	// chain of hops records ending in the iWay or a chain with no iWay at all
	task automatic build_page(input int hops, input bit too_long);
		addr_t     base;
		addr_t     off;
		line_t     rec;
		line_t     d;
		int        n_rec;
		int        nl;
		logic      hit;
		mem.delete();
		exp_ar.delete();
		exp_out.delete();
		err_at   = -1;
		base     = {12'($urandom % 32'hE00), 12'h000};
		off      = 24'(16 * (1 + $urandom % 255));  // never the record at base
		page     = base + off;
		n_rec    = too_long ? MAX_HOPS + 2 : hops + 1;
		iway_idx = too_long ? -1 : hops;
		for (int j = 0; j < n_rec; j++) begin
			rec = {$urandom, $urandom, $urandom, $urandom};
			if (j == iway_idx) begin
				exp_cls = 2'($urandom);
				rec[PTR_LSB +: 24]  = record_addr(base, j);
				rec[SIZE_LSB +: 2]  = exp_cls;
				rec[VLD_LSB +: 4]   = ($urandom % 2) ? 4'hF : 4'($urandom);
				rec[SLOT_LSB + 12 * ($urandom % 4) +: 12] = off[11:0];
				exp_md_addr = record_addr(base, j);
				exp_full    = &rec[VLD_LSB +: 4];
				exp_md_data = rec;
				hit = 1'b0;
				for (int k = 0; k < 4; k++) begin
					if (!hit && rec[SLOT_LSB + 12 * k +: 12] == off[11:0]) begin
						exp_md_data[VLD_LSB + k] = 1'b0;
						hit = 1'b1;
					end
				end
			end else begin
				rec[PTR_LSB +: 24] = record_addr(base, j + 1);
			end
			mem[record_addr(base, j)] = rec;
			exp_ar.push_back(record_addr(base, j));
		end
		if (!too_long) begin
			nl = 16 << exp_cls;
			for (int i = 0; i < nl; i++) begin
				d = {$urandom, $urandom, $urandom, $urandom};
				mem[page + 24'(16 * i)] = d;
				exp_ar.push_back(page + 24'(16 * i));
				exp_out.push_back(nibble_spread(d, 1'b0));
				exp_out.push_back(nibble_spread(d, 1'b1));
			end
		end
	endtask

	task automatic run_page(input bit expect_err, input int n_reads);
		int t;
		@(negedge clk_i);
		got_ar.delete();
		got_out.delete();
		rd_num   = 0;
		pend     = 1'b0;
		md_cnt   = 0;
		free_cnt = 0;
		done_cnt = 0;
		iway_cyc = -1;
		@(posedge clk_i);
		trigger    <= 1'b1;
		cpage_addr <= page;
		@(posedge clk_i);
		trigger <= 1'b0;
		for (t = 0; t < WAIT_MAX; t++) begin
			@(negedge clk_i);
			if (done_cnt != 0 || error)
				break;
		end
		if (t == WAIT_MAX)
			abort_run("timeout: neither done nor error arrived after trigger");
		if (expect_err) begin
			repeat (10) @(negedge clk_i);  // error has to stay up
			check("error", error, 1'b1);
			check("done count", done_cnt, 0);
			check("read count", got_ar.size(), n_reads);
		end else begin
			@(negedge clk_i);  // done must be a single pulse
			check("error", error, 1'b0);
			check("done count", done_cnt, 1);
			check("read count", got_ar.size(), n_reads);
			check("out line count", got_out.size(), exp_out.size());
			for (int i = 0; i < exp_out.size(); i++)
				check($sformatf("out_data[%0d]", i), got_out[i], exp_out[i]);
			check("md_wr count", md_cnt, 1);
			check("md_wr_addr", md_addr_got, exp_md_addr);
			check("md_wr_data", md_data_got, exp_md_data);
			check("md_wr cycle", md_cyc, iway_cyc + 2);
			check("free_push count", free_cnt, exp_full);
			if (exp_full) begin
				check("free_ptr", free_ptr_got, exp_md_addr);
				check("free_cls", free_cls_got, exp_cls);
				check("free_push cycle", free_cyc, done_cyc - 1);
			end
		end
		for (int i = 0; i < n_reads; i++)
			check($sformatf("ar_addr[%0d]", i), got_ar[i], exp_ar[i]);
	endtask

	initial begin
		void'($urandom(32377));
		rst_ni     = 1'b0;
		trigger    = 1'b0;
		cpage_addr = '0;
		ar_ready   = 1'b0;
		r_valid    = 1'b0;
		r_data     = '0;
		r_resp     = 2'b00;
		cyc        = 0;
		rd_num     = 0;
		pend       = 1'b0;
		err_at     = -1;
		iway_idx   = -1;
		md_cnt     = 0;
		free_cnt   = 0;
		done_cnt   = 0;
		apply_reset();

		for (int s = 0; s < 8; s++) begin
			build_page(s % 4, 1'b0);
			run_page(1'b0, exp_ar.size());
		end

		// bus error somewhere in the walk or the burst
		build_page($urandom % 4, 1'b0);
		err_at = $urandom % exp_ar.size();
		run_page(1'b1, err_at + 1);
		apply_reset();
		build_page($urandom % 4, 1'b0);
		run_page(1'b0, exp_ar.size());

		// no iWay within MAX_HOPS follows
		build_page(0, 1'b1);
		run_page(1'b1, MAX_HOPS + 1);
		apply_reset();
		build_page(3, 1'b0);
		run_page(1'b0, exp_ar.size());

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/zdc_top.sv */
// FIFO_DEPTH must be a power of two. out_valid cannot be stalled and error needs a reset to clear
`timescale 1ns/1ps
`default_nettype none

module zdc_top
	import zdc_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
) (
	input  wire        clk_i,
	input  wire        rst_ni,
	input  wire        trigger,
	input  wire addr_t cpage_addr,
	output logic       ar_valid,
	output addr_t      ar_addr,
	input  wire        ar_ready,
	input  wire        r_valid,
	input  wire line_t r_data,
	input  wire [1:0]  r_resp,
	output logic       md_wr_valid,
	output addr_t      md_wr_addr,
	output line_t      md_wr_data,
	output logic       out_valid,
	output xline_t     out_data,
	output logic       free_push,
	output addr_t      free_ptr,
	output size_cls_t  free_cls,
	output logic       done,
	output logic       error
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic             fifo_push;
	logic             fifo_flush;
	logic             fifo_pop;
	logic             fifo_empty;
	line_t            fifo_wdata;
	line_t            fifo_rdata;
	logic [CNT_W-1:0] fifo_count;
	logic             exp_start;
	logic             exp_done;
	logic [7:0]       exp_lines;

	rd_port_if rd ();

	assign ar_valid    = rd.ar_valid;
	assign ar_addr     = rd.ar_addr;
	assign rd.ar_ready = ar_ready;
	assign rd.r_valid  = r_valid;
	assign rd.r_data   = r_data;
	assign rd.r_resp   = r_resp;

	decomp_mngr #(.FIFO_DEPTH(FIFO_DEPTH)) u_mngr (
		.clk_i, .rst_ni, .trigger, .cpage_addr,
		.rd         (rd.mngr),
		.fifo_push, .fifo_wdata, .fifo_flush, .fifo_count,
		.exp_start, .exp_lines, .exp_done,
		.md_wr_valid, .md_wr_addr, .md_wr_data,
		.free_push, .free_ptr, .free_cls,
		.done, .error
	);

	line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk_i, .rst_ni,
		.push  (fifo_push),
		.wdata (fifo_wdata),
		.pop   (fifo_pop),
		.rdata (fifo_rdata),
		.flush (fifo_flush),
		.full  (),  // burst throttles on count
		.empty (fifo_empty),
		.count (fifo_count)
	);

	nibble_expander u_expander (
		.clk_i, .rst_ni,
		.start (exp_start),
		.lines (exp_lines),
		.done  (exp_done),
		.pop   (fifo_pop),
		.rdata (fifo_rdata),
		.empty (fifo_empty),
		.out_valid, .out_data
	);

endmodule

`default_nettype wire

/* hdl/decomp_mngr.sv */
// Responses must lag their request by a cycle or more. cpage_addr is sampled on trigger
`timescale 1ns/1ps
`default_nettype none

module decomp_mngr
	import zdc_pkg::*;
#(
	parameter  int FIFO_DEPTH = 16,
	localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
	input  wire              clk_i,
	input  wire              rst_ni,
	input  wire              trigger,
	input  wire addr_t       cpage_addr,
	rd_port_if.mngr          rd,
	output logic             fifo_push,
	output line_t            fifo_wdata,
	output logic             fifo_flush,
	input  wire [CNT_W-1:0]  fifo_count,
	output logic             exp_start,
	output logic [7:0]       exp_lines,
	input  wire              exp_done,
	output logic             md_wr_valid,
	output addr_t            md_wr_addr,
	output line_t            md_wr_data,
	output logic             free_push,
	output addr_t            free_ptr,
	output size_cls_t        free_cls,
	output logic             done,
	output logic             error
);

	localparam int HOP_W = $clog2(MAX_HOPS + 2);

	mngr_state_t      state;
	mngr_state_t      state_n;
	logic [HOP_W-1:0] hops;
	logic [7:0]       req_cnt;  // burst reads issued
	logic [7:0]       rsp_cnt;  // burst lines pushed
	logic             rd_busy;
	addr_t            cpage_q;
	addr_t            hdr_addr_q;  // record being read and finally the iWay address
	line_t            rec_q;       // iWay as read before the slot is cleared
	logic [7:0]       n_lines;
	logic             zspg_full;
	logic             is_iway;
	logic             rd_ok;
	logic             ar_fire;
	logic             burst_go;
	addr_t            burst_addr;

	assign rd_ok     = rd.r_valid && (rd.r_resp == 2'b00);
	assign ar_fire   = rd.ar_valid && rd.ar_ready;
	assign is_iway   = (rd.r_data[PTR_LSB +: $bits(addr_t)] == hdr_addr_q);
	assign n_lines   = CLS_LINES(rec_q[SIZE_LSB +: $bits(size_cls_t)]);
	assign zspg_full = &rec_q[VLD_LSB +: NUM_SLOTS];

	// at most one read in flight and only if its line fits in the FIFO
	assign burst_go   = (state == BURST) && !rd_busy && (req_cnt != n_lines) &&
	                    (fifo_count < CNT_W'(FIFO_DEPTH));
	assign burst_addr = cpage_q + {12'd0, req_cnt, 4'd0};

	assign rd.ar_valid = (state == REQ_HDR) || burst_go;
	assign rd.ar_addr  = (state == BURST) ? burst_addr : hdr_addr_q;

	assign fifo_push  = (state == BURST) && rd_ok;
	assign fifo_wdata = rd.r_data;
	assign fifo_flush = (state == FLUSH);
	assign exp_start  = (state == FLUSH);  // expander drains while the burst runs
	assign exp_lines  = n_lines;

	assign md_wr_valid = (state == CLEAR_SLOT);
	assign md_wr_addr  = hdr_addr_q;
	assign free_push   = (state == PUSH_FREE);
	assign free_ptr    = rec_q[PTR_LSB +: $bits(addr_t)];
	assign free_cls    = rec_q[SIZE_LSB +: $bits(size_cls_t)];
	assign done        = (state == DONE);
	assign error       = (state == BUS_ERROR);  // held until reset

	// invalidate the first slot holding this page
	always_comb begin : clear_slot
		logic hit;
		md_wr_data = rec_q;
		hit        = 1'b0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (!hit && rec_q[SLOT_LSB + SLOT_W*k +: SLOT_W] == cpage_q[SLOT_W-1:0]) begin
				md_wr_data[VLD_LSB + k] = 1'b0;
				hit = 1'b1;
			end
		end
	end

	always_comb begin
		state_n = state;
		case (state)
			IDLE: begin
				if (trigger)
					state_n = REQ_HDR;
			end
			REQ_HDR: begin
				if (ar_fire)
					state_n = WAIT_HDR;
			end
			WAIT_HDR: begin
				if (rd.r_valid) begin
					if (rd.r_resp != 2'b00)
						state_n = BUS_ERROR;
					else if (is_iway)
						state_n = CLEAR_SLOT;
					else if (hops == HOP_W'(MAX_HOPS))
						state_n = BUS_ERROR;  // chain too long
					else
						state_n = REQ_HDR;
				end
			end
			CLEAR_SLOT: state_n = FLUSH;
			FLUSH:      state_n = BURST;
			BURST: begin
				if (rd.r_valid) begin
					if (rd.r_resp != 2'b00)
						state_n = BUS_ERROR;
					else if (rsp_cnt == n_lines - 8'd1)
						state_n = WAIT_EXPAND;
				end
			end
			WAIT_EXPAND: begin
				if (exp_done)
					state_n = zspg_full ? PUSH_FREE : DONE;
			end
			PUSH_FREE: state_n = DONE;
			DONE:      state_n = IDLE;
			BUS_ERROR: state_n = BUS_ERROR;
			default:   state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state   <= IDLE;
			hops    <= '0;
			req_cnt <= '0;
			rsp_cnt <= '0;
			rd_busy <= 1'b0;
		end else begin
			state <= state_n;
			if (state == IDLE)
				hops <= '0;
			else if (state == WAIT_HDR && rd_ok && !is_iway)
				hops <= hops + 1'b1;
			if (state == FLUSH) begin
				req_cnt <= '0;
				rsp_cnt <= '0;
				rd_busy <= 1'b0;
			end else begin
				if (ar_fire && state == BURST) begin
					req_cnt <= req_cnt + 8'd1;
					rd_busy <= 1'b1;
				end
				if (fifo_push) begin
					rsp_cnt <= rsp_cnt + 8'd1;
					rd_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == IDLE && trigger) begin
			cpage_q    <= cpage_addr;
			hdr_addr_q <= {cpage_addr[23:12], 12'h000};  // 4 KB aligned
		end else if (state == WAIT_HDR && rd_ok) begin
			if (is_iway)
				rec_q <= rd.r_data;
			else
				hdr_addr_q <= rd.r_data[PTR_LSB +: $bits(addr_t)];
		end
	end

endmodule

`default_nettype wire

/* hdl/nibble_expander.sv */
// Expects lines to be at least 1 and the FIFO to be fed only by the page it was started for
`timescale 1ns/1ps
`default_nettype none

module nibble_expander
	import zdc_pkg::*;
(
	input  wire        clk_i,
	input  wire        rst_ni,
	input  wire        start,
	input  wire [7:0]  lines,
	output logic       done,
	output logic       pop,
	input  wire line_t rdata,
	input  wire        empty,
	output logic       out_valid,
	output xline_t     out_data
);

	typedef enum logic [2:0] {X_IDLE, X_WAIT, X_LO, X_HI, X_FIN} xp_state_t;

	xp_state_t   state;
	logic [7:0]  lines_left;
	logic [63:0] hi_q;  // upper 8 bytes wait for the second output line

	// each byte becomes two bytes, low nibble first
	function automatic xline_t expand(input logic [63:0] b);
		xline_t x;
		for (int i = 0; i < 8; i++) begin
			x[16*i +: 8]     = {4'h0, b[8*i +: 4]};
			x[16*i + 8 +: 8] = {4'h0, b[8*i + 4 +: 4]};
		end
		return x;
	endfunction

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= X_IDLE;
			lines_left <= '0;
			pop        <= 1'b0;
			done       <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			pop       <= 1'b0;
			done      <= 1'b0;
			out_valid <= 1'b0;
			case (state)
				X_IDLE: begin
					if (start) begin
						lines_left <= lines;
						state      <= X_WAIT;
					end
				end
				X_WAIT: begin
					if (!empty) begin
						pop   <= 1'b1;  // rdata is valid while pop is high
						state <= X_LO;
					end
				end
				X_LO: begin
					out_valid <= 1'b1;
					state     <= X_HI;
				end
				X_HI: begin
					out_valid  <= 1'b1;
					lines_left <= lines_left - 8'd1;
					state      <= (lines_left == 8'd1) ? X_FIN : X_WAIT;
				end
				X_FIN: begin
					done  <= 1'b1;  // high half of the last line is out now
					state <= X_IDLE;
				end
				default: state <= X_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == X_LO) begin
			out_data <= expand(rdata[63:0]);
			hi_q     <= rdata[127:64];
		end else if (state == X_HI) begin
			out_data <= expand(hi_q);
		end
	end

endmodule

`default_nettype wire

/* hdl/line_fifo.sv */
// FIFO_DEPTH must be a power of two and at least 2. A push while full or a pop while empty is ignored
`timescale 1ns/1ps
`default_nettype none

module line_fifo
	import zdc_pkg::*;
#(
	parameter  int FIFO_DEPTH = 16,
	localparam int PTR_W      = $clog2(FIFO_DEPTH),
	localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
	input  wire             clk_i,
	input  wire             rst_ni,
	input  wire             push,
	input  wire line_t      wdata,
	input  wire             pop,
	output line_t           rdata,
	input  wire             flush,
	output logic            full,
	output logic            empty,
	output logic [CNT_W-1:0] count
);

	line_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full && !flush;
	assign do_pop  = pop && !empty && !flush;
	assign rdata   = mem[rd_ptr];  // show-ahead

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

`default_nettype wire

/* hdl/rd_port_if.sv */
// Single-beat reads with one outstanding request. A nonzero r_resp marks a bus error
`timescale 1ns/1ps
`default_nettype none

interface rd_port_if
	import zdc_pkg::*;
();
	logic       ar_valid;
	addr_t      ar_addr;
	logic       ar_ready;
	logic       r_valid;   // one pulse per request
	line_t      r_data;
	logic [1:0] r_resp;

	modport mngr (
		output ar_valid, ar_addr,
		input  ar_ready, r_valid, r_data, r_resp
	);

	modport top (
		input  ar_valid, ar_addr,
		output ar_ready, r_valid, r_data, r_resp
	);

endinterface

`default_nettype wire

/* hdl/zdc_pkg.sv */
// 24-bit byte addresses and 128-bit lines. Records hold four slots and class 3 is the largest
`default_nettype none

package zdc_pkg;

	typedef logic [23:0]  addr_t;
	typedef logic [127:0] line_t;
	typedef logic [127:0] xline_t;  // one nibble per byte
	typedef logic [1:0]   size_cls_t;
	typedef logic [3:0]   pg_vld_t;

	typedef enum logic [3:0] {
		IDLE,
		REQ_HDR,
		WAIT_HDR,
		CLEAR_SLOT,
		FLUSH,
		BURST,
		WAIT_EXPAND,
		PUSH_FREE,
		DONE,
		BUS_ERROR
	} mngr_state_t;

	// metadata record layout
	localparam int PTR_LSB   = 0;   // own address in an iWay, next hop otherwise
	localparam int SIZE_LSB  = 24;
	localparam int VLD_LSB   = 26;
	localparam int SLOT_LSB  = 30;  // slot k starts at SLOT_LSB + SLOT_W*k
	localparam int SLOT_W    = 12;
	localparam int NUM_SLOTS = $bits(pg_vld_t);

	localparam int MAX_HOPS = 4;    // pointer follows allowed before the iWay

	// one 16-byte line per 16 bytes of compressed page
	function automatic logic [7:0] CLS_LINES(input size_cls_t cls);
		logic [7:0] n;
		case (cls)
			2'd0:    n = 8'd16;   // 256 B
			2'd1:    n = 8'd32;
			2'd2:    n = 8'd64;
			default: n = 8'd128;  // 2 KB
		endcase
		return n;
	endfunction

endpackage

`default_nettype wire
